// File: flist.f
+incdir+hw
hw/mem_arbiter_pkg.sv
hw/bank_arbiter.sv
hw/grant_merge.sv
hw/mem_arbiter.sv
test/bank_arbiter_properties.sv
test/mem_arbiter_checker.sv
test/tb_mem_arbiter.sv

// File: hw/bank_arbiter.sv
`timescale 1ns/1ps
`include "mem_arbiter_defines.svh"

module bank_arbiter #(
	parameter int unsigned BANK_SEL = 0
) (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  mem_arbiter_pkg::mem_req_t  reqs [`NUM_REQ],
	output mem_arbiter_pkg::bank_cmd_t cmd,
	output logic [`NUM_REQ-1:0]        grant
);

	// address top bits that map onto this bank
	localparam logic [`BANK_SEL_W-1:0] SEL = BANK_SEL[`BANK_SEL_W-1:0];

	mem_arbiter_pkg::bank_state_t state;
	mem_arbiter_pkg::bank_state_t state_next;

	// requesters asking for this bank
	logic [`NUM_REQ-1:0] hit;

	// winner among the hits
	mem_arbiter_pkg::req_id_t pick;
	logic                     pick_valid;

	// requester that currently owns the bank
	mem_arbiter_pkg::req_id_t owner;
	logic                     owned;

	// bank command for one requester
	// sprite only reads, flash loader always writes the whole word
	function automatic mem_arbiter_pkg::bank_cmd_t req_cmd(
		input mem_arbiter_pkg::req_id_t  id,
		input mem_arbiter_pkg::mem_req_t req
	);
		mem_arbiter_pkg::bank_cmd_t c;
		c.addr = req.addr[`BANK_ADDR_W-1:0];
		c.din  = '0;
		c.mask = '1;
		c.wr   = 1'b0;
		case (id)
			mem_arbiter_pkg::REQ_FL: begin
				c.din = req.wdata;
				c.wr  = 1'b1;
			end
			mem_arbiter_pkg::REQ_CPU: begin
				c.din  = req.wdata;
				c.mask = req.mask;
				c.wr   = req.wr;
			end
			default: ;
		endcase
		return c;
	endfunction

	// grant state that belongs to a requester
	function automatic mem_arbiter_pkg::bank_state_t grant_state(
		input mem_arbiter_pkg::req_id_t id
	);
		mem_arbiter_pkg::bank_state_t s;
		case (id)
			mem_arbiter_pkg::REQ_SP: s = mem_arbiter_pkg::S_GRANT_SP;
			mem_arbiter_pkg::REQ_FL: s = mem_arbiter_pkg::S_GRANT_FL;
			default:                 s = mem_arbiter_pkg::S_GRANT_CPU;
		endcase
		return s;
	endfunction

	// address decode per requester
	always_comb begin
		for (int i = 0; i < `NUM_REQ; i++) begin
			hit[i] = reqs[i].valid &&
				(reqs[i].addr[`MEM_ADDR_W-1 -: `BANK_SEL_W] == SEL);
		end
	end

	// fixed priority, walk from lowest so the highest one overwrites
	always_comb begin
		pick       = mem_arbiter_pkg::REQ_SP;
		pick_valid = 1'b0;
		for (int i = `NUM_REQ - 1; i >= 0; i--) begin
			if (hit[i]) begin
				pick       = mem_arbiter_pkg::req_id_t'(i);
				pick_valid = 1'b1;
			end
		end
	end

	// decode the owner from the grant state
	always_comb begin
		owner = mem_arbiter_pkg::REQ_SP;
		owned = 1'b1;
		case (state)
			mem_arbiter_pkg::S_GRANT_SP:  owner = mem_arbiter_pkg::REQ_SP;
			mem_arbiter_pkg::S_GRANT_FL:  owner = mem_arbiter_pkg::REQ_FL;
			mem_arbiter_pkg::S_GRANT_CPU: owner = mem_arbiter_pkg::REQ_CPU;
			default: owned = 1'b0;
		endcase
	end

	// bank command and next state
	always_comb begin
		state_next = state;

		// resting command, nothing written
		cmd.addr = '0;
		cmd.din  = '0;
		cmd.mask = '1;
		cmd.wr   = 1'b0;

		if (!owned) begin
			// accept in the same cycle, the read word shows up next cycle
			if (pick_valid) begin
				cmd        = req_cmd(pick, reqs[pick]);
				state_next = grant_state(pick);
			end
		end else begin
			cmd = req_cmd(owner, reqs[owner]);
			// valid dropped, release the bank without a stray write
			if (!reqs[owner].valid) begin
				cmd.wr     = 1'b0;
				state_next = mem_arbiter_pkg::S_IDLE;
			end
		end
	end

	// ready for the owner, held through the releasing cycle too
	always_comb begin
		grant = '0;
		if (owned) begin
			grant[owner] = 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= mem_arbiter_pkg::S_IDLE;
		end else begin
			state <= state_next;
		end
	end

endmodule

// File: hw/grant_merge.sv
`timescale 1ns/1ps
`include "mem_arbiter_defines.svh"

module grant_merge (
	input  logic [`NUM_REQ-1:0]       grants    [`NUM_BANKS],
	input  logic [`DATA_W-1:0]        bank_dout [`NUM_BANKS],
	output mem_arbiter_pkg::mem_rsp_t rsps      [`NUM_REQ]
);

	// grants seen from the requester side, one bit per bank
	logic [`NUM_BANKS-1:0] req_grant [`NUM_REQ];

	// bank read data gated by the grant of each requester
	logic [`DATA_W-1:0] gated [`NUM_REQ][`NUM_BANKS];

	// turn bank-major grants into requester-major ones
	always_comb begin
		for (int r = 0; r < `NUM_REQ; r++) begin
			for (int b = 0; b < `NUM_BANKS; b++) begin
				req_grant[r][b] = grants[b][r];
			end
		end
	end

	// a requester only ever holds one bank, so an OR is enough
	always_comb begin
		for (int r = 0; r < `NUM_REQ; r++) begin
			for (int b = 0; b < `NUM_BANKS; b++) begin
				if (req_grant[r][b]) begin
					gated[r][b] = bank_dout[b];
				end else begin
					gated[r][b] = '0;
				end
			end
		end
	end

	// one response per requester
	// zero data when no bank grants it
	always_comb begin
		for (int r = 0; r < `NUM_REQ; r++) begin
			rsps[r].ready = |req_grant[r];
			rsps[r].rdata = '0;
			for (int b = 0; b < `NUM_BANKS; b++) begin
				rsps[r].rdata = rsps[r].rdata | gated[r][b];
			end
		end
	end

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
`include "mem_arbiter_defines.svh"

module mem_arbiter (
	input  logic                       CLK,
	input  logic                       RSTb,

	// sprite controller, read only
	input  mem_arbiter_pkg::mem_req_t  sp_req,
	output mem_arbiter_pkg::mem_rsp_t  sp_rsp,

	// flash loader, write only
	input  mem_arbiter_pkg::mem_req_t  fl_req,
	output mem_arbiter_pkg::mem_rsp_t  fl_rsp,

	// CPU, read or byte masked write
	input  mem_arbiter_pkg::mem_req_t  cpu_req,
	output mem_arbiter_pkg::mem_rsp_t  cpu_rsp,

	// external single-port banks
	output mem_arbiter_pkg::bank_cmd_t bank_cmd  [`NUM_BANKS],
	input  logic [`DATA_W-1:0]         bank_dout [`NUM_BANKS]
);

	// requests in priority order
	mem_arbiter_pkg::mem_req_t reqs [`NUM_REQ];

	// responses in the same order
	mem_arbiter_pkg::mem_rsp_t rsps [`NUM_REQ];

	// grant vector of every bank
	logic [`NUM_REQ-1:0] grants [`NUM_BANKS];

	assign reqs[mem_arbiter_pkg::REQ_SP]  = sp_req;
	assign reqs[mem_arbiter_pkg::REQ_FL]  = fl_req;
	assign reqs[mem_arbiter_pkg::REQ_CPU] = cpu_req;

	assign sp_rsp  = rsps[mem_arbiter_pkg::REQ_SP];
	assign fl_rsp  = rsps[mem_arbiter_pkg::REQ_FL];
	assign cpu_rsp = rsps[mem_arbiter_pkg::REQ_CPU];

	// one arbiter per bank, banks run independently
	genvar b;
	generate
		for (b = 0; b < `NUM_BANKS; b++) begin : g_bank
			bank_arbiter #(
				.BANK_SEL (b)
			) u_bank_arbiter (
				.CLK   (CLK),
				.RSTb  (RSTb),
				.reqs  (reqs),
				.cmd   (bank_cmd[b]),
				.grant (grants[b])
			);
		end
	endgenerate

	// fold the bank grants and read data back per requester
	grant_merge u_grant_merge (
		.grants    (grants),
		.bank_dout (bank_dout),
		.rsps      (rsps)
	);

endmodule

// File: hw/mem_arbiter_defines.svh
`ifndef MEM_ARBITER_DEFINES_SVH
`define MEM_ARBITER_DEFINES_SVH

// requester side address, bank select on top of the in-bank word address
`define MEM_ADDR_W 16

// word address inside one bank
`define BANK_ADDR_W 14

// top address bits pick the bank
`define BANK_SEL_W 2

// memory word
`define DATA_W 16

// one enable per byte of the word
`define MASK_W 2

// four single-port banks of 16K words
`define NUM_BANKS 4

// sprite, flash loader and CPU
// index order is also the priority order
`define NUM_REQ 3

`endif

// File: hw/mem_arbiter_pkg.sv
`include "mem_arbiter_defines.svh"

package mem_arbiter_pkg;

	// requester index, lower index wins
	typedef logic [$clog2(`NUM_REQ)-1:0] req_id_t;

	localparam req_id_t REQ_SP  = 0;
	localparam req_id_t REQ_FL  = 1;
	localparam req_id_t REQ_CPU = 2;

	// request from one requester, held stable until ready
	typedef struct packed {
		logic                   valid;
		logic                   wr;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`DATA_W-1:0]     wdata;
		logic [`MASK_W-1:0]     mask;
	} mem_req_t;

	// response back to one requester
	typedef struct packed {
		logic               ready;
		logic [`DATA_W-1:0] rdata;
	} mem_rsp_t;

	// command to one single-port bank
	typedef struct packed {
		logic [`BANK_ADDR_W-1:0] addr;
		logic [`DATA_W-1:0]      din;
		logic [`MASK_W-1:0]      mask;
		logic                    wr;
	} bank_cmd_t;

	// per bank grant state
	typedef enum logic [1:0] {
		S_IDLE,
		S_GRANT_SP,
		S_GRANT_FL,
		S_GRANT_CPU
	} bank_state_t;

endpackage

// File: run.sh
#!/bin/sh
# build and run the mem_arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_arbiter \
	-f flist.f \
	-Mdir obj_dir

out=$(./obj_dir/Vtb_mem_arbiter || true)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

// File: test/bank_arbiter_properties.sv
`timescale 1ns/1ps
`include "mem_arbiter_defines.svh"

module bank_arbiter_properties (
	input logic                       CLK,
	input logic                       RSTb,
	input mem_arbiter_pkg::bank_cmd_t cmd,
	input logic [`NUM_REQ-1:0]        grant
);

	// one owner per bank at a time
	a_one_grant: assert property (@(posedge CLK) disable iff (!RSTb) $onehot0(grant))
		else $error("bank granted to more than one requester");

	// sprite controller only reads
	a_sp_no_write: assert property (@(posedge CLK) disable iff (!RSTb)
		grant[mem_arbiter_pkg::REQ_SP] |-> !cmd.wr)
		else $error("bank write issued while the sprite controller holds the bank");

	// reset leaves the bank without owner
	a_reset_idle: assert property (@(posedge CLK) !RSTb |=> (grant == '0))
		else $error("grant vector not empty after reset");

endmodule

bind bank_arbiter bank_arbiter_properties u_bank_arbiter_properties (
	.CLK   (CLK),
	.RSTb  (RSTb),
	.cmd   (cmd),
	.grant (grant)
);

// File: test/mem_arbiter_checker.sv
`timescale 1ns/1ps
`include "mem_arbiter_defines.svh"

module mem_arbiter_checker (
	input logic                      CLK,
	input logic                      RSTb,
	input mem_arbiter_pkg::mem_req_t req [`NUM_REQ],
	input mem_arbiter_pkg::mem_rsp_t rsp [`NUM_REQ]
);

	int errors = 0;
	int reads  = 0;
	int writes = 0;
	int cycle  = 0;

	// reference memory over the whole address space, starts at zero
	logic [`DATA_W-1:0] ref_mem [2**`MEM_ADDR_W];

	// first valid cycle and handshake cycle of the last request
	logic active   [`NUM_REQ];
	int   start    [`NUM_REQ];
	int   hs_cycle [`NUM_REQ];
	int   latency  [`NUM_REQ];

	initial begin
		for (int a = 0; a < 2**`MEM_ADDR_W; a++) begin
			ref_mem[a] = '0;
		end
		for (int r = 0; r < `NUM_REQ; r++) begin
			active[r]   = 1'b0;
			start[r]    = 0;
			hs_cycle[r] = 0;
			latency[r]  = 0;
		end
	end

	// one completed transfer of requester r
	task automatic accept(input int r);
		mem_arbiter_pkg::mem_req_t q;
		q = req[r];
		if (r == mem_arbiter_pkg::REQ_FL) begin
			// flash loader always writes the whole word
			ref_mem[q.addr] = q.wdata;
			writes++;
		end else if (r == mem_arbiter_pkg::REQ_CPU && q.wr) begin
			for (int k = 0; k < `MASK_W; k++) begin
				if (q.mask[k]) begin
					ref_mem[q.addr][k*8 +: 8] = q.wdata[k*8 +: 8];
				end
			end
			writes++;
		end else begin
			reads++;
			if (rsp[r].rdata !== ref_mem[q.addr]) begin
				errors++;
				$display("CHECK FAILED rdata %h expected %h addr %h requester %0d",
					rsp[r].rdata, ref_mem[q.addr], q.addr, r);
			end
		end
	endtask

	always @(posedge CLK) begin
		cycle <= cycle + 1;
	end

	// mid-cycle sampling, all DUT outputs settled
	always @(negedge CLK) begin
		if (RSTb) begin
			for (int r = 0; r < `NUM_REQ; r++) begin
				if (req[r].valid && !active[r]) begin
					active[r] = 1'b1;
					start[r]  = cycle;
				end
				if (req[r].valid && rsp[r].ready) begin
					active[r]   = 1'b0;
					hs_cycle[r] = cycle;
					latency[r]  = cycle - start[r];
					accept(r);
				end
				// no bank grants it, so no read data either
				if (!rsp[r].ready && rsp[r].rdata !== '0) begin
					errors++;
					$display("CHECK FAILED rdata %h expected %h requester %0d",
						rsp[r].rdata, `DATA_W'(0), r);
				end
			end
			for (int a = 0; a < `NUM_REQ; a++) begin
				for (int b = a + 1; b < `NUM_REQ; b++) begin
					if (rsp[a].ready && rsp[b].ready &&
						req[a].addr[`MEM_ADDR_W-1 -: `BANK_SEL_W] ==
						req[b].addr[`MEM_ADDR_W-1 -: `BANK_SEL_W]) begin
						errors++;
						$display("requesters %0d and %0d were both ready on one bank", a, b);
					end
				end
			end
		end
	end

	// all three started together on one bank
	task automatic check_priority();
		if (latency[mem_arbiter_pkg::REQ_SP] != 1) begin
			errors++;
			$display("CHECK FAILED sp latency %h expected %h",
				latency[mem_arbiter_pkg::REQ_SP], 1);
		end
		if (!(hs_cycle[mem_arbiter_pkg::REQ_SP] < hs_cycle[mem_arbiter_pkg::REQ_FL] &&
			hs_cycle[mem_arbiter_pkg::REQ_FL] < hs_cycle[mem_arbiter_pkg::REQ_CPU])) begin
			errors++;
			$display("ready did not arrive in the order sprite, flash loader, CPU");
		end
	endtask

	// all three started together on different idle banks
	task automatic check_parallel();
		for (int r = 0; r < `NUM_REQ; r++) begin
			if (latency[r] != 1) begin
				errors++;
				$display("CHECK FAILED latency of requester %0d %h expected %h", r, latency[r], 1);
			end
		end
	endtask

endmodule

// File: test/tb_mem_arbiter.sv
`timescale 1ns/1ps
`include "mem_arbiter_defines.svh"

module tb_mem_arbiter;

	localparam int REQS_PER_AGENT = 400;
	// random gap plus waiting behind the two other requesters
	localparam int MAX_REQ_CYCLES = 12;
	// every request back to back, plus reset, quiet and directed phases
	localparam int TIMEOUT_CYCLES = 3 * REQS_PER_AGENT * MAX_REQ_CYCLES + 5600;
	// words per bank the agents touch, so reads hit written words
	localparam int WINDOW = 8;

	logic CLK;
	logic RSTb;
	int   cycles;

	mem_arbiter_pkg::mem_req_t  req       [`NUM_REQ];
	mem_arbiter_pkg::mem_rsp_t  rsp       [`NUM_REQ];
	mem_arbiter_pkg::bank_cmd_t bank_cmd  [`NUM_BANKS];
	logic [`DATA_W-1:0]         bank_dout [`NUM_BANKS];

	// the four external banks
	logic [`DATA_W-1:0] bank_mem [`NUM_BANKS][2**`BANK_ADDR_W];

	mem_arbiter u_mem_arbiter (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.sp_req    (req[mem_arbiter_pkg::REQ_SP]),
		.sp_rsp    (rsp[mem_arbiter_pkg::REQ_SP]),
		.fl_req    (req[mem_arbiter_pkg::REQ_FL]),
		.fl_rsp    (rsp[mem_arbiter_pkg::REQ_FL]),
		.cpu_req   (req[mem_arbiter_pkg::REQ_CPU]),
		.cpu_rsp   (rsp[mem_arbiter_pkg::REQ_CPU]),
		.bank_cmd  (bank_cmd),
		.bank_dout (bank_dout)
	);

	mem_arbiter_checker u_checker (
		.CLK  (CLK),
		.RSTb (RSTb),
		.req  (req),
		.rsp  (rsp)
	);

	always #4 CLK = ~CLK;

	// masked synchronous write, read word one cycle later
	always @(posedge CLK) begin
		for (int b = 0; b < `NUM_BANKS; b++) begin
			if (bank_cmd[b].wr) begin
				for (int k = 0; k < `MASK_W; k++) begin
					if (bank_cmd[b].mask[k]) begin
						bank_mem[b][bank_cmd[b].addr][k*8 +: 8] <=
							bank_cmd[b].din[k*8 +: 8];
					end
				end
			end
			bank_dout[b] <= bank_mem[b][bank_cmd[b].addr];
		end
	end

	// raise valid, hold until ready, then release the bank
	task automatic issue(input int id, input logic wr, input logic [`MEM_ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0] wdata, input logic [`MASK_W-1:0] mask);
		mem_arbiter_pkg::mem_req_t q;
		q.valid = 1'b1;
		q.wr    = wr;
		q.addr  = addr;
		q.wdata = wdata;
		q.mask  = mask;
		@(posedge CLK);
		req[id] <= q;
		@(negedge CLK);
		while (!rsp[id].ready) begin
			@(negedge CLK);
		end
		q.valid = 1'b0;
		@(posedge CLK);
		req[id] <= q;
	endtask

	task automatic run_agent(input int id);
		logic                   wr;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`DATA_W-1:0]     wdata;
		logic [`MASK_W-1:0]     mask;
		for (int n = 0; n < REQS_PER_AGENT; n++) begin
			repeat ($urandom_range(0, 3)) @(posedge CLK);
			addr  = {2'($urandom_range(0, 3)), 14'($urandom_range(0, WINDOW - 1))};
			wdata = 16'($urandom);
			mask  = 2'($urandom);
			wr    = 1'($urandom);
			if (id == mem_arbiter_pkg::REQ_SP) begin
				wr = 1'b0;
			end else if (id == mem_arbiter_pkg::REQ_FL) begin
				wr   = 1'b1;
				mask = '1;
			end
			issue(id, wr, addr, wdata, mask);
		end
	endtask

	task automatic report_counts();
		$display("reads %0d, writes %0d, errors %0d",
			u_checker.reads, u_checker.writes, u_checker.errors);
	endtask

	initial begin
		void'($urandom(32'hfae0_d968));
		CLK  = 1'b0;
		RSTb = 1'b0;
		for (int r = 0; r < `NUM_REQ; r++) begin
			req[r] = '0;
		end
		for (int b = 0; b < `NUM_BANKS; b++) begin
			bank_dout[b] = '0;
			for (int a = 0; a < 2**`BANK_ADDR_W; a++) begin
				bank_mem[b][a] = '0;
			end
		end
		repeat (4) @(posedge CLK);
		RSTb <= 1'b1;

		fork
			run_agent(mem_arbiter_pkg::REQ_SP);
			run_agent(mem_arbiter_pkg::REQ_FL);
			run_agent(mem_arbiter_pkg::REQ_CPU);
		join

		// quiet, then all three on bank 2 together
		repeat (8) @(posedge CLK);
		fork
			issue(mem_arbiter_pkg::REQ_SP, 1'b0, 16'h8003, 16'h0000, 2'b11);
			issue(mem_arbiter_pkg::REQ_FL, 1'b1, 16'h8004, 16'hbeef, 2'b11);
			issue(mem_arbiter_pkg::REQ_CPU, 1'b1, 16'h8003, 16'h5a5a, 2'b01);
		join
		u_checker.check_priority();

		// one requester per idle bank
		repeat (8) @(posedge CLK);
		fork
			issue(mem_arbiter_pkg::REQ_SP, 1'b0, 16'h0001, 16'h0000, 2'b11);
			issue(mem_arbiter_pkg::REQ_FL, 1'b1, 16'h4002, 16'hc3a5, 2'b11);
			issue(mem_arbiter_pkg::REQ_CPU, 1'b0, 16'hc005, 16'h0000, 2'b11);
		join
		u_checker.check_parallel();

		// read back the flash word and the merged CPU word
		issue(mem_arbiter_pkg::REQ_SP, 1'b0, 16'h4002, 16'h0000, 2'b11);
		issue(mem_arbiter_pkg::REQ_CPU, 1'b0, 16'h8003, 16'h0000, 2'b11);
		repeat (4) @(posedge CLK);

		report_counts();
		if (u_checker.errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout, requests still pending after %0d cycles", TIMEOUT_CYCLES);
		report_counts();
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
